// File: verilog.f
+incdir+tests
common/rv_pkg.sv
decode/rv_decoder.sv
decode/register_file.sv
execute/rv_alu.sv
execute/execute_stage.sv
logic/retire_buffer.sv
logic/rv_alu_core.sv
tests/tb_rv_alu_core.sv

// File: tests/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

xlen_t ref_regs [REG_COUNT];    // Register state as the program sees it

////////////////////////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////////////////////////

// {funct7, funct3} of the ten register-register operations
function automatic logic [9:0] rtype_fields(input int k);
    case (k)
        0: return {7'b0000000, 3'b000};    // add
        1: return {7'b0100000, 3'b000};    // sub
        2: return {7'b0000000, 3'b001};    // sll
        3: return {7'b0000000, 3'b010};    // slt
        4: return {7'b0000000, 3'b011};    // sltu
        5: return {7'b0000000, 3'b100};    // xor
        6: return {7'b0000000, 3'b101};    // srl
        7: return {7'b0100000, 3'b101};    // sra
        8: return {7'b0000000, 3'b110};    // or
        default: return {7'b0000000, 3'b111};    // and
    endcase
endfunction

function automatic instr_t rtype_word(input logic [9:0] ops, input reg_addr_t rd,
                                      input reg_addr_t rs1, input reg_addr_t rs2);
    return {ops[9:3], rs2, rs1, ops[2:0], rd, OPC_OP};
endfunction

function automatic instr_t itype_word(input logic [2:0] f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic instr_t lui_word(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
endfunction

////////////////////////////////////////////////////////////
// Expected results
////////////////////////////////////////////////////////////

function automatic xlen_t alu_expect(input logic [2:0] f3, input logic alt,
                                     input xlen_t a, input xlen_t b);
    logic [5:0] sh;
    xlen_t      fill;
    logic       lt_s;
    logic       lt_u;
    sh   = b[5:0];
    fill = ~({XLEN{1'b1}} >> sh);    // Bits that sra copies from the sign
    lt_u = a < b;
    lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << sh;
        3'b010: return lt_s ? xlen_t'(1) : xlen_t'(0);
        3'b011: return lt_u ? xlen_t'(1) : xlen_t'(0);
        3'b100: return a ^ b;
        3'b101: return (alt && a[XLEN-1]) ? ((a >> sh) | fill) : (a >> sh);
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// Executes one instruction on ref_regs and returns what must retire
function automatic retire_t predict_retire(input instr_t ins);
    logic [2:0] f3;
    logic [5:0] f6;
    logic       legal;
    xlen_t      value;
    retire_t    r;
    f3    = ins[14:12];
    f6    = ins[31:26];
    legal = 1'b0;
    value = '0;
    if (ins[6:0] == OPC_OP) begin
        legal = ins[31:25] == 7'b0 || (ins[31:25] == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
        value = alu_expect(f3, ins[30], ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
    end else if (ins[6:0] == OPC_OP_IMM) begin
        if (f3 == 3'b001)
            legal = f6 == 6'b0;
        else if (f3 == 3'b101)
            legal = f6 == 6'b0 || f6 == 6'b010000;
        else
            legal = 1'b1;
        value = alu_expect(f3, f3 == 3'b101 && ins[30], ref_regs[ins[19:15]],
                           {{(XLEN-12){ins[31]}}, ins[31:20]});
    end else if (ins[6:0] == OPC_LUI) begin
        legal = 1'b1;
        value = {{(XLEN-32){ins[31]}}, ins[31:12], 12'b0};
    end
    if (!legal)
        value = '0;
    if (legal && ins[11:7] != 5'd0)
        ref_regs[ins[11:7]] = value;
    r.rd      = ins[11:7];
    r.value   = value;
    r.illegal = !legal;
    return r;
endfunction

`endif

// File: tests/tb_rv_alu_core.sv
`timescale 1ns/1ns

module tb_rv_alu_core import rv_pkg::*; ();

    localparam int          CLK_PERIOD = 40;
    localparam int          DRIVE_DLY  = 5;    // Input drive after the rising edge
    localparam logic [31:0] RAND_SEED  = 32'hdf03_c83b;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    logic    instr_ready;
    instr_t  instr;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;

    instr_t  program_q [$];
    retire_t expect_q [$];
    retire_t exp_head;
    int      exp_count;
    logic    program_built;
    logic    in_hs;
    logic    rt_hs;
    instr_t  in_word;
    retire_t rt_seen;

    `include "rv_ref_model.svh"

    rv_alu_core rv_alu_core_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "first error reached");
    endtask

    function automatic reg_addr_t random_reg(input int lo);
        return reg_addr_t'($urandom_range(31, lo));
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_retire_order: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid && retire_ready |-> exp_count > 0 && retire == exp_head
    ) else fail_check($sformatf("retire rd=%0d value=%h illegal=%b, expected rd=%0d value=%h %s",
        rt_seen.rd, rt_seen.value, rt_seen.illegal, exp_head.rd, exp_head.value,
        exp_count > 0 ? "" : "with nothing pending"));

    a_retire_stall: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    ) else fail_check("retire payload changed while retire_ready was low");

    a_reset_idle: assert property (
        @(posedge clk) $fell(rst) |-> !retire_valid && instr_ready
    ) else fail_check("core not idle right after reset");

    // Handshakes sampled at the falling edge, queue updated just after the rising edge
    always begin
        @(negedge clk);
        in_hs   = !rst && instr_valid && instr_ready;
        rt_hs   = !rst && retire_valid && retire_ready;
        in_word = instr;
        rt_seen = retire;
        @(posedge clk);
        #1;
        if (rt_hs && expect_q.size() > 0)
            void'(expect_q.pop_front());
        if (in_hs)
            expect_q.push_back(predict_retire(in_word));
        exp_count = expect_q.size();
        if (exp_count > 0)
            exp_head = expect_q[0];
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic build_program();
        logic [2:0]  f3;
        logic [11:0] imm;
        reg_addr_t   prev;
        for (int k = 0; k < 10; k++)    // Untouched registers read as zero
            program_q.push_back(rtype_word(rtype_fields(k), 5'd1, 5'(k + 11), 5'(k + 21)));
        for (int r = 1; r < 16; r++) begin    // Wide random values, each step depends on the last
            program_q.push_back(lui_word(5'(r), 20'($urandom)));
            program_q.push_back(itype_word(3'b001, 5'(r), 5'(r), 12'($urandom_range(40, 20))));
            program_q.push_back(lui_word(5'd16, 20'($urandom)));
            program_q.push_back(rtype_word(rtype_fields(5), 5'(r), 5'(r), 5'd16));
            program_q.push_back(itype_word(3'b000, 5'(r), 5'(r), 12'($urandom)));
        end
        prev = 5'd1;
        for (int k = 0; k < 60; k++) begin
            program_q.push_back(rtype_word(rtype_fields($urandom_range(9, 0)), random_reg(1),
                                           $urandom_range(1, 0) ? prev : random_reg(0),
                                           random_reg(0)));
            prev = program_q[$][11:7];
        end
        program_q.push_back(itype_word(3'b000, 5'd17, 5'd3, 12'hfff));    // addi -1
        program_q.push_back(itype_word(3'b000, 5'd18, 5'd4, 12'h800));    // addi -2048
        program_q.push_back(itype_word(3'b010, 5'd19, 5'd5, 12'hffb));
        program_q.push_back(itype_word(3'b011, 5'd20, 5'd6, 12'hfff));
        program_q.push_back(itype_word(3'b100, 5'd21, 5'd7, 12'hfff));
        program_q.push_back(itype_word(3'b110, 5'd22, 5'd8, 12'h8f0));
        program_q.push_back(itype_word(3'b111, 5'd23, 5'd9, 12'hf0f));
        program_q.push_back(itype_word(3'b001, 5'd24, 5'd10, 12'h03f));    // slli 63
        program_q.push_back(lui_word(5'd28, 20'h80000));    // Bit 31 set, negative result
        program_q.push_back(itype_word(3'b101, 5'd29, 5'd28, 12'h404));    // srai 4
        program_q.push_back(itype_word(3'b101, 5'd30, 5'd28, 12'h43f));    // srai 63
        program_q.push_back(itype_word(3'b101, 5'd31, 5'd28, 12'h03f));    // srli 63
        program_q.push_back(lui_word(5'd27, 20'hfffff));
        for (int k = 0; k < 30; k++) begin
            f3  = 3'($urandom_range(7, 0));
            imm = 12'($urandom);
            if (f3 == 3'b001)
                imm[11:6] = 6'b0;
            else if (f3 == 3'b101)
                imm[11:6] = $urandom_range(1, 0) ? 6'b010000 : 6'b0;
            program_q.push_back(itype_word(f3, random_reg(1), random_reg(0), imm));
        end
        program_q.push_back(itype_word(3'b000, 5'd0, 5'd1, 12'h005));    // x0 writes dropped
        program_q.push_back(rtype_word(rtype_fields(0), 5'd0, 5'd2, 5'd3));
        program_q.push_back(lui_word(5'd0, 20'h12345));
        program_q.push_back(rtype_word(rtype_fields(0), 5'd18, 5'd0, 5'd3));
        program_q.push_back(rtype_word(rtype_fields(8), 5'd16, 5'd0, 5'd0));
        program_q.push_back(32'h0000_b083);    // Load opcode, rd x1
        program_q.push_back(rtype_word(rtype_fields(0), 5'd5, 5'd1, 5'd0));
        program_q.push_back(rtype_word(10'b0000001_000, 5'd2, 5'd3, 5'd4));    // mul
        program_q.push_back(rtype_word(10'b0100000_001, 5'd3, 5'd4, 5'd5));
        program_q.push_back(itype_word(3'b001, 5'd4, 5'd5, 12'h040));    // slli bad funct6
        program_q.push_back(itype_word(3'b001, 5'd4, 5'd5, 12'h400));
        program_q.push_back(itype_word(3'b101, 5'd6, 5'd7, 12'h440));
        program_q.push_back({25'($urandom), 7'b0010111});    // auipc
        program_q.push_back({25'($urandom), 7'b1101111});    // jal
        program_q.push_back({25'($urandom), 7'b0111011});    // 32-bit op
        for (int r = 1; r < REG_COUNT; r++)    // Read back every register after the illegal ones
            program_q.push_back(rtype_word(rtype_fields(8), 5'(r), 5'(r), 5'd0));
    endtask

    task automatic send_instr(input instr_t word);
        logic taken;
        if ($urandom_range(3, 0) == 0) begin
            repeat ($urandom_range(3, 1)) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
        end
        instr_valid = 1'b1;
        instr       = word;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;
            @(posedge clk);
            #DRIVE_DLY;
        end
        instr_valid = 1'b0;
        instr       = instr_t'($urandom);    // Noise while idle
    endtask

    initial begin
        @(negedge rst);
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            retire_ready = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin
        wait (program_built);
        #((program_q.size() * 8 + 100) * CLK_PERIOD);
        $display("Timeout: the core stopped retiring with %0d results pending", exp_count);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        retire_ready  = 1'b0;
        exp_count     = 0;
        exp_head      = '0;
        program_built = 1'b0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < REG_COUNT; i++)
            ref_regs[i] = '0;
        build_program();
        program_built = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        foreach (program_q[i])
            send_instr(program_q[i]);
        wait (exp_count == 0);
        repeat (4) @(posedge clk);    // Catch any extra retire
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: logic/rv_alu_core.sv
`timescale 1ns/1ns

module rv_alu_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    output logic    instr_ready,
    input  instr_t  instr,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      d_valid;
    decoded_t  dec;
    src_t      src;
    logic      ex_ready;
    logic      rb_ready;
    wb_t       wb;
    logic      capture;
    retire_t   ex_result;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    rv_decoder rv_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .ex_ready    (ex_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .d_valid     (d_valid),
        .dec         (dec),
        .src         (src)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)    // Written back from execute
    );

    ////////////////////////////////////////////////////////////
    // Processing and output side
    ////////////////////////////////////////////////////////////

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .d_valid  (d_valid),
        .dec      (dec),
        .src      (src),
        .ex_ready (ex_ready),
        .rb_ready (rb_ready),
        .wb       (wb),
        .capture  (capture),
        .result   (ex_result)
    );

    retire_buffer retire_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .capture      (capture),
        .result       (ex_result),
        .rb_ready     (rb_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

endmodule

// File: logic/retire_buffer.sv
`timescale 1ns/1ns

module retire_buffer import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    capture,
    input  retire_t result,
    output logic    rb_ready,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    // Empty, or the current entry leaves this cycle
    assign rb_ready = !retire_valid || retire_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else if (capture) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;    // Drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            retire <= result;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stream checks
    ////////////////////////////////////////////////////////////

    a_retire_hold: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    ) else $error("retire payload changed while stalled");

    // Execute stage must not push into a full buffer
    a_capture_ready: assert property (
        @(posedge clk) disable iff (rst) capture |-> rb_ready
    ) else $error("capture while retire buffer is full");

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     d_valid,
    input  decoded_t dec,
    input  src_t     src,
    output logic     ex_ready,
    input  logic     rb_ready,
    output wb_t      wb,
    output logic     capture,
    output retire_t  result
);

    logic      fwd_we;
    reg_addr_t fwd_rd;
    xlen_t     fwd_data;
    xlen_t     op_a;
    xlen_t     rs2_val;
    xlen_t     op_b;
    xlen_t     alu_result;

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    assign capture  = d_valid && rb_ready;
    assign ex_ready = !d_valid || rb_ready;

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    // The decoder read at the same edge as the last write, so it missed it.
    // fwd_rd is never x0 while fwd_we is set.
    assign op_a    = (fwd_we && fwd_rd == src.rs1) ? fwd_data : dec.rs1;
    assign rs2_val = (fwd_we && fwd_rd == src.rs2) ? fwd_data : dec.rs2;
    assign op_b    = dec.use_imm ? dec.imm : rs2_val;

    rv_alu alu_inst (
        .op     (dec.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_we <= 1'b0;
        end else if (capture) begin
            fwd_we <= wb.we;    // Non-writing capture leaves nothing to forward
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fwd_rd   <= wb.rd;
            fwd_data <= wb.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write-back and retire payload
    ////////////////////////////////////////////////////////////

    assign wb.we   = capture && dec.write_en;
    assign wb.rd   = dec.rd;
    assign wb.data = alu_result;

    assign result.rd      = dec.rd;
    assign result.value   = dec.illegal ? '0 : alu_result;
    assign result.illegal = dec.illegal;

endmodule

// File: execute/rv_alu.sv
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
    input  alu_op_e op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   result
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = b[SHAMT_W-1:0];    // Upper bits of b are ignored
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;    // Zero fill
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;    // Sign fill from bit 63
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: decode/register_file.sv
`timescale 1ns/1ns

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  wb_t       wb
);

    xlen_t regs [REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;    // Written at the capture edge
        end
    end

    // Combinational reads, x0 always zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // The decoder filters rd == 0, nothing here does
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst) wb.we |-> wb.rd != '0
    ) else $error("register write targets x0");

endmodule

// File: decode/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  instr_t    instr,
    input  logic      ex_ready,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    output logic      d_valid,
    output decoded_t  dec,
    output src_t      src
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    logic       legal;
    logic       alt_form;
    decoded_t   dec_next;

    ////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];    // RV64 shifts use six shamt bits
    assign rd     = instr[11:7];

    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    // LUI has no rs1 and only OP has rs2, those fields hold immediate bits
    assign rs1_addr = (opcode == OPC_LUI) ? '0 : instr[19:15];
    assign rs2_addr = (opcode == OPC_OP) ? instr[24:20] : '0;

    always_comb begin
        legal    = 1'b0;
        alt_form = 1'b0;
        case (opcode)
            OPC_OP: begin
                alt_form = instr[30];
                legal    = (funct7 == F7_BASE) ||
                           (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OPC_OP_IMM: begin
                // Only srai has an alternate form, addi keeps bit 30 as imm
                alt_form = (funct3 == F3_SR) && instr[30];
                if (funct3 == F3_SLL)
                    legal = (funct6 == F6_BASE);
                else if (funct3 == F3_SR)
                    legal = (funct6 == F6_BASE) || (funct6 == F6_ALT);
                else
                    legal = 1'b1;
            end
            OPC_LUI: begin
                legal = 1'b1;    // rs1 reads x0, so imm + 0
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_next.alu_op   = legal && opcode != OPC_LUI ? alu_op_e'({alt_form, funct3}) : ALU_ADD;
        dec_next.rs1      = rs1_data;
        dec_next.rs2      = rs2_data;
        dec_next.rd       = rd;
        dec_next.use_imm  = (opcode != OPC_OP);
        dec_next.imm      = (opcode == OPC_LUI) ? imm_u : imm_i;
        dec_next.write_en = legal && (rd != '0);    // The one x0 check on the write side
        dec_next.illegal  = !legal;
    end

    ////////////////////////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////////////////////////

    assign instr_ready = ex_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else if (ex_ready) begin
            d_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready && instr_valid) begin
            dec     <= dec_next;
            src.rs1 <= rs1_addr;    // Kept for the forwarding match
            src.rs2 <= rs2_addr;
        end
    end

endmodule

// File: common/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////////////////////////
    // Architecture sizes
    ////////////////////////////////////////////////////////////

    localparam int XLEN      = 64;    // RV64I data width
    localparam int REG_COUNT = 32;    // Integer register count
    localparam int SHAMT_W   = 6;     // Shift amount bits in RV64I

    typedef logic [XLEN-1:0]                xlen_t;
    typedef logic [$clog2(REG_COUNT)-1:0]   reg_addr_t;
    typedef logic [31:0]                    instr_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Major opcodes that the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // Register-register
        OPC_OP_IMM = 7'b0010011,    // Register-immediate
        OPC_LUI    = 7'b0110111     // Upper immediate
    } opcode_e;

    // Low three bits follow funct3, bit 3 is the alternate form (instr[30])
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    localparam logic [2:0] F3_ADD = 3'b000;     // add, sub, addi
    localparam logic [2:0] F3_SLL = 3'b001;     // sll, slli
    localparam logic [2:0] F3_SR  = 3'b101;     // srl, sra and their immediate forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub, sra
    localparam logic [5:0] F6_BASE = 6'b000000;     // Upper bits of slli, srli
    localparam logic [5:0] F6_ALT  = 6'b010000;     // Upper bits of srai

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    // Decode register contents, operands already read
    typedef struct packed {
        alu_op_e   alu_op;
        xlen_t     rs1;         // rs1 value
        xlen_t     rs2;         // rs2 value
        reg_addr_t rd;
        logic      use_imm;     // Second operand from imm
        xlen_t     imm;
        logic      write_en;    // Legal and rd not x0
        logic      illegal;
    } decoded_t;

    // Source indices kept for forwarding
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
    } src_t;

    // Register-file write port
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    // One finished instruction
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     value;
        logic      illegal;
    } retire_t;

endpackage
